/* conv_accel_top.f */
+incdir+.
conv_accel_pkg.sv
conv_scan.sv
conv_coeff_bank.sv
conv_mac.sv
conv_writeback.sv
conv_accel_top.sv
tb_conv_accel.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_conv_accel \
  -f conv_accel_top.f -o sim_conv_accel

./obj_dir/sim_conv_accel | tee sim.log

if grep -q "^Regression passed$" sim.log; then
  exit 0
fi
exit 1

/* tb_conv_accel.sv */
// Image memory answers iaddr in the same cycle; model assumes the 64x64 image and header weights
`timescale 1ns/1ps
`include "conv_accel_params.svh"

module tb_conv_accel;

  localparam int CLK_PERIOD  = 10;
  localparam int DIM         = `CONV_IMG_DIM;
  localparam int NPIX        = DIM * DIM;
  localparam int WATCHDOG_NS = (2 * NPIX * `CONV_TAPS + 1000) * CLK_PERIOD;

  logic                   clk;
  logic                   reset;
  logic                   ready;
  conv_accel_pkg::pixel_t idata;
  logic                   busy;
  conv_accel_pkg::addr_t  iaddr;
  logic                   cwr;
  logic [2:0]             csel;
  conv_accel_pkg::addr_t  caddr_wr;
  conv_accel_pkg::pixel_t cdata_wr;

  logic [31:0]            lfsr_state;
  conv_accel_pkg::pixel_t img_mem [0:NPIX-1];
  conv_accel_pkg::pixel_t res_k0 [0:NPIX-1];
  conv_accel_pkg::pixel_t res_k1 [0:NPIX-1];
  int                     k0_writes [0:NPIX-1];
  int                     k1_writes [0:NPIX-1];
  int                     total_writes;
  int                     zero_seen;
  int                     pos_seen;
  conv_accel_pkg::pixel_t k0_w [0:8];
  conv_accel_pkg::pixel_t k1_w [0:8];

  conv_accel_top conv_accel_top_i (
    .clk      (clk),
    .reset    (reset),
    .ready    (ready),
    .idata    (idata),
    .busy     (busy),
    .iaddr    (iaddr),
    .cwr      (cwr),
    .csel     (csel),
    .caddr_wr (caddr_wr),
    .cdata_wr (cdata_wr)
  );

  // Combinational image memory
  assign idata = img_mem[iaddr];

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ====================
  // Helpers
  task automatic check_value(input string name, input longint expected, input longint actual);
    if (expected != actual) begin
      $display("Error: %s expected %0d actual %0d", name, expected, actual);
      $display("Regression failed");
      $fatal(1);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Regression failed");
    $fatal(1);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
    return bits;
  endfunction

  // Zero-padded 3x3 window, bias at 16 fraction bits, then round and ReLU
  function automatic conv_accel_pkg::pixel_t expected_result(input int kernel, input int row,
                                                             input int col);
    longint sum;
    longint pix;
    longint wt;
    int     t;
    int     nr;
    int     nc;
    sum = 0;
    for (t = 0; t < `CONV_TAPS; t++) begin
      nr = row + t / 3 - 1;
      nc = col + t % 3 - 1;
      pix = 0;
      if (nr >= 0 && nr < DIM && nc >= 0 && nc < DIM) begin
        pix = longint'(img_mem[nr * DIM + nc]);
      end
      wt = (kernel == 0) ? longint'(k0_w[t]) : longint'(k1_w[t]);
      sum = sum + pix * wt;
    end
    if (kernel == 0) begin
      sum = sum + (longint'(conv_accel_pkg::pixel_t'(`CONV_K0_BIAS)) <<< `CONV_BIAS_SHIFT);
    end else begin
      sum = sum + (longint'(conv_accel_pkg::pixel_t'(`CONV_K1_BIAS)) <<< `CONV_BIAS_SHIFT);
    end
    if (sum <= 0) begin
      return '0;
    end
    return conv_accel_pkg::pixel_t'(((sum >>> `CONV_FRAC_SHIFT) + 1) >>> 1);
  endfunction

  // ====================
  // Result memories, captured where outputs are stable
  always @(negedge clk) begin
    if (!reset && cwr) begin
      total_writes++;
      if (csel == 3'b001) begin
        res_k0[caddr_wr] = cdata_wr;
        k0_writes[caddr_wr]++;
      end else if (csel == 3'b010) begin
        res_k1[caddr_wr] = cdata_wr;
        k1_writes[caddr_wr]++;
      end else begin
        report_failure($sformatf("Write with unexpected csel %b at address %0d", csel, caddr_wr));
      end
    end
  end

  task automatic run_pass(input int pass_no);
    int   a;
    logic prev_k1_last;
    total_writes = 0;
    for (a = 0; a < NPIX; a++) begin
      k0_writes[a] = 0;
      k1_writes[a] = 0;
    end
    @(negedge clk);
    ready = 1'b1;
    @(negedge clk);
    ready = 1'b0;
    check_value($sformatf("pass%0d_busy_rise", pass_no), 1, busy);
    // Pixel 0 tap 0 is padded, so the center address shows
    check_value($sformatf("pass%0d_first_iaddr", pass_no), 0, iaddr);
    prev_k1_last = 1'b0;
    while (busy) begin
      prev_k1_last = cwr && (csel == 3'b010) && (caddr_wr == NPIX - 1);
      @(negedge clk);
    end
    // busy must drop on the cycle after the last kernel-1 write
    check_value($sformatf("pass%0d_busy_fall", pass_no), 1, prev_k1_last);
  endtask

  task automatic verify_pass(input int pass_no);
    int                     a;
    int                     row;
    int                     col;
    logic                   edge_r;
    logic                   edge_c;
    string                  region;
    conv_accel_pkg::pixel_t exp0;
    conv_accel_pkg::pixel_t exp1;
    check_value($sformatf("pass%0d_write_total", pass_no), 2 * NPIX, total_writes);
    for (a = 0; a < NPIX; a++) begin
      row = a / DIM;
      col = a % DIM;
      edge_r = (row == 0) || (row == DIM - 1);
      edge_c = (col == 0) || (col == DIM - 1);
      region = (edge_r && edge_c) ? "corner" : ((edge_r || edge_c) ? "border" : "interior");
      check_value($sformatf("pass%0d_k0_writes[%0d]", pass_no, a), 1, k0_writes[a]);
      check_value($sformatf("pass%0d_k1_writes[%0d]", pass_no, a), 1, k1_writes[a]);
      exp0 = expected_result(0, row, col);
      exp1 = expected_result(1, row, col);
      check_value($sformatf("pass%0d_k0_%s[%0d]", pass_no, region, a), exp0, res_k0[a]);
      check_value($sformatf("pass%0d_k1_%s[%0d]", pass_no, region, a), exp1, res_k1[a]);
      if (pass_no == 1) begin
        zero_seen += (res_k0[a] == 0) + (res_k1[a] == 0);
        pos_seen  += (res_k0[a] != 0) + (res_k1[a] != 0);
      end
    end
  endtask

  // ====================
  // Main sequence
  initial begin
    int a;
    ready        = 1'b0;
    reset        = 1'b1;
    total_writes = 0;
    zero_seen    = 0;
    pos_seen     = 0;
    lfsr_state   = 32'hc41a;
    k0_w = '{`CONV_K0_W0, `CONV_K0_W1, `CONV_K0_W2, `CONV_K0_W3, `CONV_K0_W4,
             `CONV_K0_W5, `CONV_K0_W6, `CONV_K0_W7, `CONV_K0_W8};
    k1_w = '{`CONV_K1_W0, `CONV_K1_W1, `CONV_K1_W2, `CONV_K1_W3, `CONV_K1_W4,
             `CONV_K1_W5, `CONV_K1_W6, `CONV_K1_W7, `CONV_K1_W8};
    for (a = 0; a < NPIX; a++) begin
      img_mem[a] = conv_accel_pkg::pixel_t'(random_bits(`CONV_DATA_W));
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_value("idle_busy", 0, busy);
      check_value("idle_cwr", 0, cwr);
      check_value("idle_csel", 0, csel);
    end
    run_pass(1);
    verify_pass(1);
    if (zero_seen == 0) begin
      report_failure("No result was clamped to zero by ReLU");
    end
    if (pos_seen == 0) begin
      report_failure("No positive result was produced");
    end
    // Restart from DONE with the same image
    run_pass(2);
    verify_pass(2);
    $display("Regression passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the DUT did not finish both passes in time");
    $display("Regression failed");
    $fatal(1);
  end

endmodule

/* conv_accel_top.sv */
// Convolution engine top; one 64x64 pass per ready pulse, combinational image memory assumed
`timescale 1ns/1ps
`include "conv_accel_params.svh"

module conv_accel_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ready,
  input  conv_accel_pkg::pixel_t idata,
  output logic                   busy,
  output conv_accel_pkg::addr_t  iaddr,
  output logic                   cwr,
  output logic [2:0]             csel,
  output conv_accel_pkg::addr_t  caddr_wr,
  output conv_accel_pkg::pixel_t cdata_wr
);

  conv_accel_pkg::tap_t      tap;
  logic                      tap_valid;
  conv_accel_pkg::coeff_t    coeff;
  conv_accel_pkg::pixel_t    bias0;
  conv_accel_pkg::pixel_t    bias1;
  conv_accel_pkg::sum_pair_t sums;
  logic                      last_written;

  // ====================
  // Address and tap generation
  conv_scan conv_scan_i (
    .clk          (clk),
    .reset        (reset),
    .ready        (ready),
    .last_written (last_written),
    .busy         (busy),
    .iaddr        (iaddr),
    .tap          (tap),
    .tap_valid    (tap_valid)
  );

  conv_coeff_bank conv_coeff_bank_i (
    .tap_idx (tap.tap_idx),
    .coeff   (coeff),
    .bias0   (bias0),
    .bias1   (bias1)
  );

  // ====================
  // Datapath
  conv_mac conv_mac_i (
    .clk       (clk),
    .reset     (reset),
    .tap       (tap),
    .tap_valid (tap_valid),
    .idata     (idata),
    .coeff     (coeff),
    .bias0     (bias0),
    .bias1     (bias1),
    .sums      (sums)
  );

  conv_writeback conv_writeback_i (
    .clk          (clk),
    .reset        (reset),
    .sums         (sums),
    .cwr          (cwr),
    .csel         (csel),
    .caddr_wr     (caddr_wr),
    .cdata_wr     (cdata_wr),
    .last_written (last_written)
  );

endmodule

/* conv_writeback.sv */
// Writes kernel 0 then kernel 1 per pixel; valid pulses must be at least 2 cycles apart
`timescale 1ns/1ps
`include "conv_accel_params.svh"

module conv_writeback (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_accel_pkg::sum_pair_t sums,
  output logic                      cwr,
  output logic [2:0]                csel,
  output conv_accel_pkg::addr_t     caddr_wr,
  output conv_accel_pkg::pixel_t    cdata_wr,
  output logic                      last_written
);

  localparam logic [2:0] CSEL_IDLE = 3'b000;
  localparam logic [2:0] CSEL_K0   = 3'b001;
  localparam logic [2:0] CSEL_K1   = 3'b010;
  localparam conv_accel_pkg::addr_t LAST_ADDR =
    conv_accel_pkg::addr_t'(`CONV_IMG_DIM * `CONV_IMG_DIM - 1);

  conv_accel_pkg::pixel_t relu0;
  conv_accel_pkg::pixel_t relu1;
  conv_accel_pkg::pixel_t k1_data_q;
  logic                   k1_pend_q;

  // Round half up at bit 15, drop to 20 bits; non-positive sums give 0
  function automatic conv_accel_pkg::pixel_t round_relu(input conv_accel_pkg::acc_t acc);
    logic [`CONV_ACC_W-`CONV_FRAC_SHIFT-1:0] rounded;
    rounded = acc[`CONV_ACC_W-1:`CONV_FRAC_SHIFT] + 1'b1;
    if (acc > 0) begin
      return rounded[`CONV_DATA_W:1];
    end
    return '0;
  endfunction

  assign relu0 = round_relu(sums.sum0);
  assign relu1 = round_relu(sums.sum1);

  // ====================
  // Write sequencer
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      cwr          <= 1'b0;
      csel         <= CSEL_IDLE;
      caddr_wr     <= '0;
      cdata_wr     <= '0;
      last_written <= 1'b0;
      k1_pend_q    <= 1'b0;
    end else begin
      last_written <= 1'b0;
      if (sums.valid) begin
        cwr       <= 1'b1;
        csel      <= CSEL_K0;
        caddr_wr  <= sums.addr;
        cdata_wr  <= relu0;
        k1_pend_q <= 1'b1;
      end else if (k1_pend_q) begin
        // Same address as the kernel-0 write
        cwr          <= 1'b1;
        csel         <= CSEL_K1;
        cdata_wr     <= k1_data_q;
        k1_pend_q    <= 1'b0;
        last_written <= (caddr_wr == LAST_ADDR);
      end else begin
        cwr  <= 1'b0;
        csel <= CSEL_IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (sums.valid) begin
      k1_data_q <= relu1;
    end
  end

endmodule

/* conv_mac.sv */
// Two-lane MAC; taps of one pixel must arrive back to back, first to last, with idata same-cycle
`timescale 1ns/1ps
`include "conv_accel_params.svh"

module conv_mac (
  input  logic                      clk,
  input  logic                      reset,
  input  conv_accel_pkg::tap_t      tap,
  input  logic                      tap_valid,
  input  conv_accel_pkg::pixel_t    idata,
  input  conv_accel_pkg::coeff_t    coeff,
  input  conv_accel_pkg::pixel_t    bias0,
  input  conv_accel_pkg::pixel_t    bias1,
  output conv_accel_pkg::sum_pair_t sums
);

  conv_accel_pkg::pixel_t          sample;
  logic                            p_vld_q;
  logic                            p_first_q;
  logic                            p_last_q;
  conv_accel_pkg::addr_t           p_addr_q;
  logic signed [`CONV_PROD_W-1:0]  prod0_q;
  logic signed [`CONV_PROD_W-1:0]  prod1_q;
  conv_accel_pkg::acc_t            bias0_ext;
  conv_accel_pkg::acc_t            bias1_ext;
  logic                            a_vld_q;
  conv_accel_pkg::addr_t           a_addr_q;
  conv_accel_pkg::acc_t            acc0_q;
  conv_accel_pkg::acc_t            acc1_q;
  logic                            s_vld_q;
  conv_accel_pkg::addr_t           s_addr_q;
  conv_accel_pkg::acc_t            s_sum0_q;
  conv_accel_pkg::acc_t            s_sum1_q;

  // Zero padding
  assign sample = tap.pad ? '0 : idata;

  assign bias0_ext = conv_accel_pkg::acc_t'(bias0) <<< `CONV_BIAS_SHIFT;
  assign bias1_ext = conv_accel_pkg::acc_t'(bias1) <<< `CONV_BIAS_SHIFT;

  // ====================
  // Stage 1, products
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      p_vld_q   <= 1'b0;
      p_first_q <= 1'b0;
      p_last_q  <= 1'b0;
    end else begin
      p_vld_q   <= tap_valid;
      p_first_q <= tap.first;
      p_last_q  <= tap.last;
    end
  end

  always_ff @(posedge clk) begin
    prod0_q  <= sample * coeff.k0;
    prod1_q  <= sample * coeff.k1;
    p_addr_q <= tap.addr;
  end

  // ====================
  // Stage 2, accumulate; restart on first tap, bias on last
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      a_vld_q <= 1'b0;
    end else begin
      a_vld_q <= p_vld_q && p_last_q;
    end
  end

  always_ff @(posedge clk) begin
    if (p_vld_q) begin
      acc0_q <= (p_first_q ? conv_accel_pkg::acc_t'(0) : acc0_q) +
                conv_accel_pkg::acc_t'(prod0_q) + (p_last_q ? bias0_ext : '0);
      acc1_q <= (p_first_q ? conv_accel_pkg::acc_t'(0) : acc1_q) +
                conv_accel_pkg::acc_t'(prod1_q) + (p_last_q ? bias1_ext : '0);
      if (p_last_q) begin
        a_addr_q <= p_addr_q;
      end
    end
  end

  // ====================
  // Stage 3, hold the finished pair while the next pixel accumulates
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      s_vld_q <= 1'b0;
    end else begin
      s_vld_q <= a_vld_q;
    end
  end

  always_ff @(posedge clk) begin
    if (a_vld_q) begin
      s_addr_q <= a_addr_q;
      s_sum0_q <= acc0_q;
      s_sum1_q <= acc1_q;
    end
  end

  assign sums = '{valid: s_vld_q, addr: s_addr_q, sum0: s_sum0_q, sum1: s_sum1_q};

  a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
    sums.valid |=> !sums.valid);

endmodule

/* conv_coeff_bank.sv */
// Constant weight table of both kernels; tap numbers 9 to 15 give zero weights
`timescale 1ns/1ps
`include "conv_accel_params.svh"

module conv_coeff_bank (
  input  conv_accel_pkg::tap_idx_t tap_idx,
  output conv_accel_pkg::coeff_t   coeff,
  output conv_accel_pkg::pixel_t   bias0,
  output conv_accel_pkg::pixel_t   bias1
);

  // ====================
  // Weight lookup
  always_comb begin
    case (tap_idx)
      4'd0: begin
        coeff = '{k0: `CONV_K0_W0, k1: `CONV_K1_W0};
      end
      4'd1: begin
        coeff = '{k0: `CONV_K0_W1, k1: `CONV_K1_W1};
      end
      4'd2: begin
        coeff = '{k0: `CONV_K0_W2, k1: `CONV_K1_W2};
      end
      4'd3: begin
        coeff = '{k0: `CONV_K0_W3, k1: `CONV_K1_W3};
      end
      // Center tap
      4'd4: begin
        coeff = '{k0: `CONV_K0_W4, k1: `CONV_K1_W4};
      end
      4'd5: begin
        coeff = '{k0: `CONV_K0_W5, k1: `CONV_K1_W5};
      end
      4'd6: begin
        coeff = '{k0: `CONV_K0_W6, k1: `CONV_K1_W6};
      end
      4'd7: begin
        coeff = '{k0: `CONV_K0_W7, k1: `CONV_K1_W7};
      end
      4'd8: begin
        coeff = '{k0: `CONV_K0_W8, k1: `CONV_K1_W8};
      end
      default: begin
        coeff = '0;
      end
    endcase
  end

  // Biases in the same Q4.16 format as the weights
  assign bias0 = `CONV_K0_BIAS;
  assign bias1 = `CONV_K1_BIAS;

endmodule

/* conv_scan.sv */
// Walks a 64x64 image row-major, nine taps per pixel with no gaps; restarts only from IDLE or DONE
`timescale 1ns/1ps
`include "conv_accel_params.svh"

module conv_scan (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  ready,
  input  logic                  last_written,
  output logic                  busy,
  output conv_accel_pkg::addr_t iaddr,
  output conv_accel_pkg::tap_t  tap,
  output logic                  tap_valid
);

  localparam int POS_W    = `CONV_ADDR_W / 2;
  localparam int LAST_POS = `CONV_IMG_DIM - 1;
  localparam int K_DIM    = 3;
  localparam conv_accel_pkg::tap_idx_t LAST_TAP = conv_accel_pkg::tap_idx_t'(`CONV_TAPS - 1);

  conv_accel_pkg::scan_state_t state_q;
  logic [POS_W-1:0]            row_q;
  logic [POS_W-1:0]            col_q;
  conv_accel_pkg::tap_idx_t    idx_q;
  logic [POS_W-1:0]            nxt_row;
  logic [POS_W-1:0]            nxt_col;
  conv_accel_pkg::tap_idx_t    nxt_idx;
  logic [1:0]                  d_row;
  logic [1:0]                  d_col;
  logic [POS_W+1:0]            nb_row;
  logic [POS_W+1:0]            nb_col;
  conv_accel_pkg::tap_t        nxt_tap;
  conv_accel_pkg::addr_t       nxt_iaddr;
  logic                        fetch_done;
  logic                        start;
  logic                        load;
  logic [POS_W-1:0]            row_off;
  logic [POS_W-1:0]            col_off;

  assign fetch_done = (state_q == conv_accel_pkg::FETCH) && (idx_q == LAST_TAP) &&
                      (row_q == LAST_POS) && (col_q == LAST_POS);
  assign start = ((state_q == conv_accel_pkg::IDLE) || (state_q == conv_accel_pkg::DONE)) && ready;
  assign load  = start || ((state_q == conv_accel_pkg::FETCH) && !fetch_done);
  assign tap_valid = (state_q == conv_accel_pkg::FETCH);

  // Next tap position, pixel 0 tap 0 when starting
  always_comb begin
    nxt_row = '0;
    nxt_col = '0;
    nxt_idx = '0;
    if (state_q == conv_accel_pkg::FETCH) begin
      nxt_row = row_q;
      nxt_col = col_q;
      nxt_idx = idx_q + 1'b1;
      if (idx_q == LAST_TAP) begin
        nxt_idx = '0;
        nxt_col = col_q + 1'b1;
        if (col_q == LAST_POS) begin
          nxt_row = row_q + 1'b1;
        end
      end
    end
  end

  // Neighbor of the window; wraps above LAST_POS when off the edge
  always_comb begin
    d_row  = 2'(nxt_idx / K_DIM);
    d_col  = 2'(nxt_idx % K_DIM);
    nb_row = {2'b00, nxt_row} + {{POS_W{1'b0}}, d_row} - 1'b1;
    nb_col = {2'b00, nxt_col} + {{POS_W{1'b0}}, d_col} - 1'b1;
    nxt_tap.tap_idx = nxt_idx;
    nxt_tap.pad     = (nb_row > LAST_POS) || (nb_col > LAST_POS);
    nxt_tap.first   = (nxt_idx == '0);
    nxt_tap.last    = (nxt_idx == LAST_TAP);
    nxt_tap.addr    = {nxt_row, nxt_col};
    nxt_iaddr = nxt_tap.pad ? nxt_tap.addr : {nb_row[POS_W-1:0], nb_col[POS_W-1:0]};
  end

  // ====================
  // Control FSM
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state_q <= conv_accel_pkg::IDLE;
      busy    <= 1'b0;
    end else begin
      case (state_q)
        conv_accel_pkg::IDLE,
        conv_accel_pkg::DONE: begin
          if (ready) begin
            state_q <= conv_accel_pkg::FETCH;
            busy    <= 1'b1;
          end else begin
            state_q <= conv_accel_pkg::IDLE;
          end
        end
        conv_accel_pkg::FETCH: begin
          if (fetch_done) begin
            state_q <= conv_accel_pkg::DRAIN;
          end
        end
        conv_accel_pkg::DRAIN: begin
          if (last_written) begin
            state_q <= conv_accel_pkg::DONE;
            busy    <= 1'b0;
          end
        end
        default: state_q <= conv_accel_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      row_q <= '0;
      col_q <= '0;
      idx_q <= '0;
      tap   <= '0;
      iaddr <= '0;
    end else if (load) begin
      row_q <= nxt_row;
      col_q <= nxt_col;
      idx_q <= nxt_idx;
      tap   <= nxt_tap;
      iaddr <= nxt_iaddr;
    end
  end

  // Offsets of the fetch address from the center, biased by one
  assign row_off = iaddr[`CONV_ADDR_W-1:POS_W] - tap.addr[`CONV_ADDR_W-1:POS_W] + 1'b1;
  assign col_off = iaddr[POS_W-1:0] - tap.addr[POS_W-1:0] + 1'b1;

  a_tap_addr: assert property (@(posedge clk) disable iff (reset)
    tap_valid |-> (tap.pad ? (iaddr == tap.addr) : ((row_off <= 2) && (col_off <= 2))));

endmodule

/* conv_accel_pkg.sv */
// Shared types of the convolution engine; all widths follow the macros in conv_accel_params.svh
`include "conv_accel_params.svh"

package conv_accel_pkg;

  // ====================
  // Data words
  typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
  typedef logic [`CONV_ADDR_W-1:0] addr_t;
  // Products carry 32 fraction bits, the bias is aligned to match
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;
  typedef logic [$clog2(`CONV_TAPS)-1:0] tap_idx_t;

  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    DRAIN,
    DONE
  } scan_state_t;

  // ====================
  // Bundles between blocks

  // One tap of the 3x3 window
  typedef struct packed {
    tap_idx_t tap_idx;
    logic     pad;    // neighbor lies outside the image
    logic     first;
    logic     last;
    addr_t    addr;   // center pixel, not the fetch address
  } tap_t;

  // Weights of both kernels for one tap
  typedef struct packed {
    pixel_t k0;
    pixel_t k1;
  } coeff_t;

  // Finished window sums of one pixel
  typedef struct packed {
    logic  valid;
    addr_t addr;
    acc_t  sum0;
    acc_t  sum1;
  } sum_pair_t;

endpackage

/* conv_accel_params.svh */
// Fixed 64x64 image with 12-bit addresses; weights are signed Q4.16, results truncated to 20 bits
`ifndef CONV_ACCEL_PARAMS_SVH
`define CONV_ACCEL_PARAMS_SVH

// ====================
// Geometry and widths
`define CONV_IMG_DIM     64
`define CONV_ADDR_W      12
`define CONV_DATA_W      20
`define CONV_PROD_W      40
`define CONV_ACC_W       44
`define CONV_TAPS        9
`define CONV_FRAC_SHIFT  15
`define CONV_BIAS_SHIFT  16

// ====================
// Kernel 0, taps row by row from the top-left neighbor
`define CONV_K0_W0   20'h0A89E
`define CONV_K0_W1   20'h092D5
`define CONV_K0_W2   20'h06D43
`define CONV_K0_W3   20'h01004
`define CONV_K0_W4   20'hF8F71
`define CONV_K0_W5   20'hF6E54
`define CONV_K0_W6   20'hFA6D7
`define CONV_K0_W7   20'hFC834
`define CONV_K0_W8   20'hFAC19
`define CONV_K0_BIAS 20'h01310

// Kernel 1
`define CONV_K1_W0   20'hFDB55
`define CONV_K1_W1   20'h02992
`define CONV_K1_W2   20'hFC994
`define CONV_K1_W3   20'h050FD
`define CONV_K1_W4   20'h02F20
`define CONV_K1_W5   20'h0202D
`define CONV_K1_W6   20'h03BD7
`define CONV_K1_W7   20'hFD369
`define CONV_K1_W8   20'h05E68
`define CONV_K1_BIAS 20'hF7295

`endif
